//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_debug_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(OBJ_DIR)

//--- design/debug_loader.sv
`timescale 1ns/1ps

module debug_loader #(
  parameter int ADDR_W = 6
) (
  input  logic                          i_clock,
  input  logic                          i_reset,
  input  debug_proto_pkg::serial_byte_t i_rx_byte,
  input  logic                          i_rx_valid,
  input  logic                          i_soft_reset_ack,
  output logic                          o_tx_start,
  output debug_proto_pkg::serial_byte_t o_tx_byte,
  output logic                          o_soft_reset_n,
  output logic                          o_mem_we,
  output logic [ADDR_W-1:0]             o_mem_addr,
  output mips_isa_pkg::instr_word_t     o_mem_wdata,
  output logic                          o_run_start,
  output logic                          o_step_mode
);

  localparam int NBYTES = mips_isa_pkg::BYTES_PER_WORD;
  localparam int BCNT_W = $clog2(NBYTES);
  localparam logic [BCNT_W-1:0] LAST_BYTE = BCNT_W'(NBYTES - 1);

  // One-hot state bits.
  localparam int ST_IDLE       = 0;
  localparam int ST_SOFT_RESET = 1;
  localparam int ST_WAIT_LOAD  = 2;
  localparam int ST_LOAD       = 3;
  localparam int ST_WAIT_START = 4;

  localparam logic [4:0] S_IDLE       = 5'b00001;
  localparam logic [4:0] S_SOFT_RESET = 5'b00010;
  localparam logic [4:0] S_WAIT_LOAD  = 5'b00100;
  localparam logic [4:0] S_LOAD       = 5'b01000;
  localparam logic [4:0] S_WAIT_START = 5'b10000;

  logic [4:0]                state;
  logic [BCNT_W-1:0]         byte_cnt;
  logic [ADDR_W-1:0]         wr_addr;
  mips_isa_pkg::instr_word_t word_q;
  mips_isa_pkg::instr_word_t word_next;
  logic                      load_byte;
  logic                      load_last;
  logic                      is_start_cmd;
  logic                      ack_seen;

  always_comb begin
    word_next.bytes = {word_q.bytes[NBYTES-2:0], i_rx_byte};  // MSB first.
  end

  assign load_byte    = state[ST_LOAD] && i_rx_valid;
  assign load_last    = load_byte && (byte_cnt == LAST_BYTE);
  assign ack_seen     = state[ST_SOFT_RESET] && i_soft_reset_ack;
  assign is_start_cmd = (i_rx_byte == debug_proto_pkg::CMD_RUN_CONT) ||
                        (i_rx_byte == debug_proto_pkg::CMD_RUN_STEP);

  //////////////////////////////////////////////////////////////////////
  // Command FSM.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state          <= S_IDLE;
      o_soft_reset_n <= 1'b1;
      o_tx_start     <= 1'b0;
      o_mem_we       <= 1'b0;
      o_run_start    <= 1'b0;
      o_step_mode    <= 1'b0;
      byte_cnt       <= '0;
      wr_addr        <= '0;
    end else begin
      o_tx_start  <= 1'b0;  // Strobes.
      o_mem_we    <= 1'b0;
      o_run_start <= 1'b0;
      case (1'b1)
        state[ST_IDLE]: begin
          if (i_rx_valid && (i_rx_byte == debug_proto_pkg::CMD_SOFT_RESET)) begin
            o_soft_reset_n <= 1'b0;  // Held until the core answers.
            state          <= S_SOFT_RESET;
          end
        end
        state[ST_SOFT_RESET]: begin
          if (ack_seen) begin
            o_soft_reset_n <= 1'b1;
            o_tx_start     <= 1'b1;  // Send ACK_BYTE.
            state          <= S_WAIT_LOAD;
          end
        end
        state[ST_WAIT_LOAD]: begin
          if (i_rx_valid && (i_rx_byte == debug_proto_pkg::CMD_LOAD)) begin
            byte_cnt <= '0;
            wr_addr  <= '0;
            state    <= S_LOAD;
          end
        end
        state[ST_LOAD]: begin
          if (load_byte) begin
            byte_cnt <= byte_cnt + 1'b1;
          end
          if (load_last) begin
            o_mem_we <= 1'b1;
            wr_addr  <= wr_addr + 1'b1;
            if (word_next == '0) begin  // Terminator word.
              state <= S_WAIT_START;
            end
          end
        end
        state[ST_WAIT_START]: begin
          if (i_rx_valid && is_start_cmd) begin
            o_run_start <= 1'b1;
            o_step_mode <= i_rx_byte[debug_proto_pkg::STEP_MODE_BIT];
            state       <= S_IDLE;
          end
        end
        default: begin
          o_soft_reset_n <= 1'b1;
          state          <= S_IDLE;
        end
      endcase
    end
  end

  // Word assembly and write data.
  always_ff @(posedge i_clock) begin
    if (load_byte) begin
      word_q <= word_next;
    end
    if (load_last) begin
      o_mem_addr  <= wr_addr;
      o_mem_wdata <= word_next;
    end
    if (ack_seen) begin
      o_tx_byte <= debug_proto_pkg::ACK_BYTE;
    end
  end

endmodule

//--- design/debug_proto_pkg.sv
package debug_proto_pkg;

  ////////////////////////////////////////////////////////////////////////
  // Serial framing, 8N1.
  ////////////////////////////////////////////////////////////////////////

  localparam int DATA_BITS  = 8;               // Payload bits per frame.
  localparam int FRAME_BITS = DATA_BITS + 2;   // Start, data, stop.

  typedef logic [DATA_BITS-1:0] serial_byte_t;

  ////////////////////////////////////////////////////////////////////////
  // Host command bytes.
  ////////////////////////////////////////////////////////////////////////

  localparam serial_byte_t CMD_SOFT_RESET = 8'h00;  // Core soft reset.
  localparam serial_byte_t CMD_LOAD       = 8'h01;  // Program load follows.
  localparam serial_byte_t ACK_BYTE       = 8'h01;  // Reply after soft reset.
  localparam serial_byte_t CMD_RUN_CONT   = 8'h03;  // Run continuously.
  localparam serial_byte_t CMD_RUN_STEP   = 8'h07;  // Run one step per pulse.

  // Bit of a start command that picks step mode.
  localparam int STEP_MODE_BIT = 2;

endpackage

//--- design/debug_top.sv
`timescale 1ns/1ps

module debug_top #(
  parameter int CLKS_PER_BIT = 8,
  parameter int ADDR_W       = 6,
  parameter int HALT_OPCODE  = 0
) (
  input  logic                      i_clock,
  input  logic                      i_reset,
  input  logic                      i_rxd,
  input  logic                      i_step,
  output logic                      o_txd,
  output logic [ADDR_W-1:0]         o_pc,
  output mips_isa_pkg::instr_word_t o_instr,
  output logic                      o_instr_valid,
  output logic                      o_halted
);

  debug_proto_pkg::serial_byte_t rx_byte;
  logic                          rx_valid;
  debug_proto_pkg::serial_byte_t tx_byte;
  logic                          tx_start;
  logic                          soft_reset_n;
  logic                          soft_reset_ack;
  logic                          mem_we;
  logic [ADDR_W-1:0]             mem_addr;
  mips_isa_pkg::instr_word_t     mem_wdata;
  logic                          run_start;
  logic                          step_mode;
  logic [ADDR_W-1:0]             rd_addr;
  mips_isa_pkg::instr_word_t     rd_data;

  //////////////////////////////////////////////////////////////////////
  // Serial side.
  //////////////////////////////////////////////////////////////////////

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_rxd      (i_rxd),
    .o_rx_byte  (rx_byte),
    .o_rx_valid (rx_valid)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_tx_start (tx_start),
    .i_tx_byte  (tx_byte),
    .o_txd      (o_txd),
    .o_tx_busy  ()  // One byte per soft reset, never back to back.
  );

  //////////////////////////////////////////////////////////////////////
  // Loader, program store and fetch.
  //////////////////////////////////////////////////////////////////////

  debug_loader #(.ADDR_W(ADDR_W)) debug_loader_inst (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_rx_byte        (rx_byte),
    .i_rx_valid       (rx_valid),
    .i_soft_reset_ack (soft_reset_ack),
    .o_tx_start       (tx_start),
    .o_tx_byte        (tx_byte),
    .o_soft_reset_n   (soft_reset_n),
    .o_mem_we         (mem_we),
    .o_mem_addr       (mem_addr),
    .o_mem_wdata      (mem_wdata),
    .o_run_start      (run_start),
    .o_step_mode      (step_mode)
  );

  program_memory #(.ADDR_W(ADDR_W)) program_memory_inst (
    .i_clock (i_clock),
    .i_we    (mem_we),
    .i_waddr (mem_addr),
    .i_wdata (mem_wdata),
    .i_raddr (rd_addr),
    .o_rdata (rd_data)
  );

  run_control #(
    .ADDR_W      (ADDR_W),
    .HALT_OPCODE (HALT_OPCODE)
  ) run_control_inst (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_soft_reset_n   (soft_reset_n),
    .o_soft_reset_ack (soft_reset_ack),
    .i_run_start      (run_start),
    .i_step_mode      (step_mode),
    .i_step           (i_step),
    .o_rd_addr        (rd_addr),
    .i_rd_data        (rd_data),
    .o_pc             (o_pc),
    .o_instr          (o_instr),
    .o_instr_valid    (o_instr_valid),
    .o_halted         (o_halted)
  );

endmodule

//--- design/mips_isa_pkg.sv
package mips_isa_pkg;

  localparam int INSTR_W        = 32;                 // Instruction word width.
  localparam int OPCODE_W       = 6;                  // Primary opcode field.
  localparam int REST_W         = INSTR_W - OPCODE_W; // Everything below it.
  localparam int BYTES_PER_WORD = INSTR_W / debug_proto_pkg::DATA_BITS;

  ////////////////////////////////////////////////////////////////////////
  // One instruction word, two views.
  ////////////////////////////////////////////////////////////////////////

  // The serial side sees bytes, most significant first on the line;
  // the fetch side only looks at the opcode.
  typedef union packed {
    debug_proto_pkg::serial_byte_t [BYTES_PER_WORD-1:0] bytes;  // Byte view.
    struct packed {
      logic [OPCODE_W-1:0] opcode;  // Bits 31:26.
      logic [REST_W-1:0]   rest;    // Bits 25:0.
    } fields;
  } instr_word_t;

endpackage

//--- design/program_memory.sv
`timescale 1ns/1ps

module program_memory #(
  parameter int ADDR_W = 6
) (
  input  logic                      i_clock,
  input  logic                      i_we,
  input  logic [ADDR_W-1:0]         i_waddr,
  input  mips_isa_pkg::instr_word_t i_wdata,
  input  logic [ADDR_W-1:0]         i_raddr,
  output mips_isa_pkg::instr_word_t o_rdata
);

  localparam int DEPTH = 2 ** ADDR_W;

  mips_isa_pkg::instr_word_t mem [0:DEPTH-1];

  always_ff @(posedge i_clock) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
    o_rdata <= mem[i_raddr];  // One cycle read.
  end

endmodule

//--- design/run_control.sv
`timescale 1ns/1ps

module run_control #(
  parameter int ADDR_W      = 6,
  parameter int HALT_OPCODE = 0
) (
  input  logic                      i_clock,
  input  logic                      i_reset,
  input  logic                      i_soft_reset_n,
  output logic                      o_soft_reset_ack,
  input  logic                      i_run_start,
  input  logic                      i_step_mode,
  input  logic                      i_step,
  output logic [ADDR_W-1:0]         o_rd_addr,
  input  mips_isa_pkg::instr_word_t i_rd_data,
  output logic [ADDR_W-1:0]         o_pc,
  output mips_isa_pkg::instr_word_t o_instr,
  output logic                      o_instr_valid,
  output logic                      o_halted
);

  localparam logic [mips_isa_pkg::OPCODE_W-1:0] HALT_OP =
    HALT_OPCODE[mips_isa_pkg::OPCODE_W-1:0];

  localparam logic [1:0] RUN_STOP    = 2'd0;
  localparam logic [1:0] RUN_FETCH   = 2'd1;  // Address at the memory.
  localparam logic [1:0] RUN_PRESENT = 2'd2;  // Read data is valid.

  logic [1:0] run_state;
  logic       running;  // Armed by a start, cleared on halt.
  logic       is_halt;

  assign is_halt = (i_rd_data.fields.opcode == HALT_OP);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      run_state        <= RUN_STOP;
      running          <= 1'b0;
      o_rd_addr        <= '0;
      o_soft_reset_ack <= 1'b0;
      o_instr_valid    <= 1'b0;
      o_halted         <= 1'b0;
    end else begin
      o_soft_reset_ack <= 1'b0;
      o_instr_valid    <= 1'b0;
      if (!i_soft_reset_n) begin
        o_soft_reset_ack <= ~o_soft_reset_ack;  // One pulse per request.
        run_state        <= RUN_STOP;
        running          <= 1'b0;
        o_rd_addr        <= '0;
        o_halted         <= 1'b0;
      end else begin
        case (run_state)
          RUN_STOP: begin
            if (i_run_start) begin
              running <= 1'b1;
              if (!i_step_mode) begin
                run_state <= RUN_FETCH;
              end
            end else if (running && i_step_mode && i_step) begin
              run_state <= RUN_FETCH;
            end
          end
          RUN_FETCH: run_state <= RUN_PRESENT;
          RUN_PRESENT: begin
            o_instr_valid <= 1'b1;
            if (is_halt) begin
              o_halted  <= 1'b1;  // Halt word is still shown.
              running   <= 1'b0;
              run_state <= RUN_STOP;
            end else begin
              o_rd_addr <= o_rd_addr + 1'b1;
              run_state <= i_step_mode ? RUN_STOP : RUN_FETCH;
            end
          end
          default: run_state <= RUN_STOP;
        endcase
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (run_state == RUN_PRESENT) begin
      o_pc    <= o_rd_addr;
      o_instr <= i_rd_data;
    end
  end

endmodule

//--- design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic                          i_clock,
  input  logic                          i_reset,
  input  logic                          i_rxd,
  output debug_proto_pkg::serial_byte_t o_rx_byte,
  output logic                          o_rx_valid
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int BIT_W = $clog2(debug_proto_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(debug_proto_pkg::DATA_BITS - 1);

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  logic             rxd_meta;
  logic             rxd_sync;
  logic             rxd_prev;
  logic [1:0]       state;
  logic [CNT_W-1:0] clk_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic             sample_bit;

  assign sample_bit = (state == RX_DATA) && (clk_cnt == LAST_CNT);  // Mid data bit.

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      rxd_meta   <= 1'b1;  // Line idles high.
      rxd_sync   <= 1'b1;
      rxd_prev   <= 1'b1;
      state      <= RX_IDLE;
      clk_cnt    <= '0;
      bit_cnt    <= '0;
      o_rx_valid <= 1'b0;
    end else begin
      rxd_meta   <= i_rxd;
      rxd_sync   <= rxd_meta;
      rxd_prev   <= rxd_sync;
      o_rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (rxd_prev && !rxd_sync) begin  // Falling edge of start bit.
            state   <= RX_START;
            clk_cnt <= '0;
          end
        end
        RX_START: begin
          if (clk_cnt == HALF_CNT) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rxd_sync ? RX_IDLE : RX_DATA;  // Drop a glitch.
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (sample_bit) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
              state <= RX_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          if (clk_cnt == LAST_CNT) begin  // Middle of stop bit.
            o_rx_valid <= 1'b1;
            clk_cnt    <= '0;
            state      <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB arrives first, so shift in from the top.
  always_ff @(posedge i_clock) begin
    if (sample_bit) begin
      o_rx_byte <= {rxd_sync, o_rx_byte[debug_proto_pkg::DATA_BITS-1:1]};
    end
  end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic                          i_clock,
  input  logic                          i_reset,
  input  logic                          i_tx_start,
  input  debug_proto_pkg::serial_byte_t i_tx_byte,
  output logic                          o_txd,
  output logic                          o_tx_busy
);

  localparam int FRAME_BITS = debug_proto_pkg::FRAME_BITS;
  localparam int CNT_W      = $clog2(CLKS_PER_BIT + 1);
  localparam int BIT_W      = $clog2(FRAME_BITS);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(FRAME_BITS - 1);

  logic [FRAME_BITS-1:0] frame;    // Bit 0 is on the line.
  logic [CNT_W-1:0]      clk_cnt;
  logic [BIT_W-1:0]      bit_cnt;

  assign o_txd = frame[0];

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      frame     <= '1;  // Idle high.
      o_tx_busy <= 1'b0;
      clk_cnt   <= '0;
      bit_cnt   <= '0;
    end else if (!o_tx_busy) begin
      if (i_tx_start) begin
        frame     <= {1'b1, i_tx_byte, 1'b0};  // Stop, data, start.
        o_tx_busy <= 1'b1;
        clk_cnt   <= '0;
        bit_cnt   <= '0;
      end
    end else if (clk_cnt == LAST_CNT) begin
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
      frame   <= {1'b1, frame[FRAME_BITS-1:1]};  // Ones fill behind the frame.
      if (bit_cnt == LAST_BIT) begin
        o_tx_busy <= 1'b0;  // End of stop bit.
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

//--- sim.f
design/debug_proto_pkg.sv
design/mips_isa_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/debug_loader.sv
design/program_memory.sv
design/run_control.sv
design/debug_top.sv
sim/tb_debug_top.sv

//--- sim/tb_debug_top.sv
`timescale 1ns/1ps

module tb_debug_top;

  localparam int CLKS_PER_BIT = 8;
  localparam int ADDR_W       = 6;
  localparam int HALT_OPCODE  = 0;
  localparam int GAP          = 2;    // Idle cycles between host bytes.
  localparam int QUIET        = 100;  // Window that must stay silent.
  localparam int STEP_IDLE    = 8;    // Silent cycles between steps.
  localparam int OPC_W        = mips_isa_pkg::OPCODE_W;
  localparam int REST_W       = mips_isa_pkg::REST_W;
  localparam logic [31:0] SEED = 32'ha8cd_395d;
  localparam logic [OPC_W-1:0] HALT_OP = OPC_W'(HALT_OPCODE);

  logic                      clock;
  logic                      reset;
  logic                      rxd;
  logic                      step;
  logic                      txd;
  logic [ADDR_W-1:0]         pc;
  mips_isa_pkg::instr_word_t instr;
  logic                      instr_valid;
  logic                      halted;

  logic [31:0]                   rng_state;
  int                            cycle_count = 0;
  int                            cycle_limit = 0;
  int                            len_a;
  int                            len_b;
  mips_isa_pkg::instr_word_t     progs[$];     // Program A, then program B.
  mips_isa_pkg::instr_word_t     exp_word_q[$];
  logic [ADDR_W-1:0]             exp_pc_q[$];
  debug_proto_pkg::serial_byte_t tx_q[$];      // Bytes seen on o_txd.

  debug_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .ADDR_W       (ADDR_W),
    .HALT_OPCODE  (HALT_OPCODE)
  ) debug_top_inst (
    .i_clock       (clock),
    .i_reset       (reset),
    .i_rxd         (rxd),
    .i_step        (step),
    .o_txd         (txd),
    .o_pc          (pc),
    .o_instr       (instr),
    .o_instr_valid (instr_valid),
    .o_halted      (halted)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////
  // Checks and random numbers.
  ////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_byte(input string name, input debug_proto_pkg::serial_byte_t got,
                            input debug_proto_pkg::serial_byte_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_instr(input string name, input mips_isa_pkg::instr_word_t got,
                             input mips_isa_pkg::instr_word_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pc(input string name, input logic [ADDR_W-1:0] got,
                          input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Host side.
  ////////////////////////////////////////////////////////////////////

  // Body words with non-halt opcodes, a halt word, then the terminator.
  task automatic add_program(output int n_words);
    int                        body;
    mips_isa_pkg::instr_word_t w;
    body = 4 + int'(next_random() % 17);
    for (int i = 0; i < body; i++) begin
      w.fields.opcode = OPC_W'(1 + next_random() % 63);
      w.fields.rest   = REST_W'(next_random());
      progs.push_back(w);
    end
    w.fields.opcode = HALT_OP;
    w.fields.rest   = REST_W'(next_random() | 32'd1);  // Never all zero.
    progs.push_back(w);
    progs.push_back('0);
    n_words = body + 2;
  endtask

  task automatic send_byte(input debug_proto_pkg::serial_byte_t b);
    logic [debug_proto_pkg::FRAME_BITS-1:0] frame;
    frame = {1'b1, b, 1'b0};  // Stop, data, start.
    for (int i = 0; i < debug_proto_pkg::FRAME_BITS; i++) begin
      @(posedge clock);
      rxd <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clock);
    end
    repeat (GAP) @(posedge clock);
  endtask

  task automatic send_program(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      for (int k = mips_isa_pkg::BYTES_PER_WORD - 1; k >= 0; k--) begin
        send_byte(progs[i].bytes[k]);  // MSB first.
      end
    end
  endtask

  // Loads the model with everything up to and including the halt word.
  task automatic expect_words(input int first, input int count);
    for (int i = 0; i < count - 1; i++) begin
      exp_word_q.push_back(progs[first + i]);
      exp_pc_q.push_back(ADDR_W'(i));
    end
  endtask

  task automatic wait_ack();
    while (tx_q.size() == 0) @(negedge clock);
    check_byte("o_txd byte", tx_q.pop_front(), debug_proto_pkg::ACK_BYTE);
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) @(negedge clock);
    if (tx_q.size() != 0) begin
      $display("Unexpected byte %h on o_txd at %0t", tx_q[0], $time);
      abort_run();
    end
  endtask

  task automatic pulse_step();
    @(posedge clock);
    step <= 1'b1;
    @(posedge clock);
    step <= 1'b0;
  endtask

  task automatic soft_reset_and_load(input int first, input int count);
    send_byte(debug_proto_pkg::CMD_SOFT_RESET);
    wait_ack();
    check_flag("o_halted", halted, 1'b0);
    send_byte(debug_proto_pkg::CMD_LOAD);
    send_program(first, count);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Monitors and timeout.
  ////////////////////////////////////////////////////////////////////

  initial begin : txd_monitor
    debug_proto_pkg::serial_byte_t b;
    forever begin
      @(negedge clock);
      if (reset === 1'b1 && txd === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clock);  // Middle of start bit.
        if (txd !== 1'b0) begin
          $display("Start bit on o_txd did not hold at %0t", $time);
          abort_run();
        end
        for (int i = 0; i < debug_proto_pkg::DATA_BITS; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clock);
          b[i] = txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clock);
        if (txd !== 1'b1) begin
          $display("Missing stop bit on o_txd at %0t", $time);
          abort_run();
        end
        tx_q.push_back(b);
      end
    end
  end

  always @(negedge clock) begin : instr_monitor
    mips_isa_pkg::instr_word_t want;
    if (reset === 1'b1 && instr_valid === 1'b1) begin
      if (exp_word_q.size() == 0) begin
        $display("Instruction strobe at %0t with none expected, o_pc %0d", $time, pc);
        abort_run();
      end else begin
        want = exp_word_q.pop_front();
        check_pc("o_pc", pc, exp_pc_q.pop_front());
        check_instr("o_instr", instr, want);
        check_flag("o_halted", halted, want.fields.opcode == HALT_OP);
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles without finishing the tests", cycle_count);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Test sequence.
  ////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0]                   r;
    debug_proto_pkg::serial_byte_t noise;
    int                            n_noise;
    reset     = 1'b0;
    rxd       = 1'b1;
    step      = 1'b0;
    rng_state = SEED;
    add_program(len_a);
    add_program(len_b);
    n_noise = 2 + int'(next_random() % 4);
    // Bytes on the line, four acknowledges, fetches, steps and quiet windows, doubled.
    cycle_limit = 2 * ((n_noise + 16 + 8 * len_a + 4 * len_b) * (10 * CLKS_PER_BIT + GAP)
                  + 4 * (2 * len_a + len_b) + len_a * (STEP_IDLE + 2) + 10 * QUIET) + 32;
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    repeat (4) @(posedge clock);

    // Idle noise is ignored; soft reset answers once.
    for (int i = 0; i < n_noise; i++) begin
      r     = next_random();
      noise = r[7:0];
      if (noise inside {8'h00, 8'h01, 8'h03, 8'h07}) begin
        noise = 8'ha5;
      end
      send_byte(noise);
    end
    expect_quiet(QUIET);
    send_byte(debug_proto_pkg::CMD_SOFT_RESET);
    wait_ack();
    expect_quiet(QUIET);

    // Continuous run of program A.
    send_byte(debug_proto_pkg::CMD_LOAD);
    send_program(0, len_a);
    expect_words(0, len_a);
    send_byte(debug_proto_pkg::CMD_RUN_CONT);
    while (exp_word_q.size() != 0) @(negedge clock);
    expect_quiet(QUIET);

    // Step run of program A.
    soft_reset_and_load(0, len_a);
    send_byte(debug_proto_pkg::CMD_RUN_STEP);
    expect_quiet(QUIET);  // Nothing before the first step.
    for (int i = 0; i < len_a - 1; i++) begin
      exp_word_q.push_back(progs[i]);
      exp_pc_q.push_back(ADDR_W'(i));
      pulse_step();
      while (exp_word_q.size() != 0) @(negedge clock);
      expect_quiet(STEP_IDLE);  // Nothing until the next step.
    end
    pulse_step();  // Past the halt.
    expect_quiet(QUIET);

    // New program B after another soft reset.
    soft_reset_and_load(len_a, len_b);
    expect_words(len_a, len_b);
    send_byte(debug_proto_pkg::CMD_RUN_CONT);
    while (exp_word_q.size() != 0) @(negedge clock);
    expect_quiet(QUIET);

    // Out of order commands.
    send_byte(debug_proto_pkg::CMD_LOAD);
    expect_quiet(QUIET);
    send_byte(debug_proto_pkg::CMD_SOFT_RESET);
    wait_ack();
    send_byte(debug_proto_pkg::CMD_RUN_CONT);
    expect_quiet(QUIET);

    $display("RESULT: PASS");
    $finish;
  end

endmodule
